/* include/keyer_cfg.svh */
// ----------------------------------------------------------------------
// iambic keyer configuration
// fixed widths and time base constants shared by rtl and testbench
// ----------------------------------------------------------------------
`ifndef KEYER_CFG_SVH
`define KEYER_CFG_SVH

// ----------------------------------------------------------------------
// time base
// ----------------------------------------------------------------------
`define KEYER_CLK_PER_MS 8        // clk cycles per 1 ms tick, 48000 on hw

// ----------------------------------------------------------------------
// paddle capture
// ----------------------------------------------------------------------
`define KEYER_REJECT_MS 5         // closed ticks before pressed, max 14
`define KEYER_ADJ_MS 2            // added to quarter dot capture window

// ----------------------------------------------------------------------
// sidetone
// ----------------------------------------------------------------------
`define KEYER_PHASE_W 16          // phase accumulator width

`endif

/* project.f */
+incdir+include
rtl/keyer_time_pkg.sv
rtl/keyer_ctrl_pkg.sv
rtl/ms_tick_gen.sv
rtl/paddle_debounce.sv
rtl/iambic_sequencer.sv
rtl/sidetone_gen.sv
rtl/cw_keyer_top.sv
tests/cw_keyer_chk.sv
tests/cw_keyer_tb.sv

/* rtl/cw_keyer_top.sv */
// ----------------------------------------------------------------------
// iambic cw keyer top
// tick generator, paddle debouncers, sequencer and sidetone
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cw_keyer_top (
  input  logic                        clk,
  input  logic                        rstb,
  input  logic                        paddle_dot_n,   // active low
  input  logic                        paddle_dash_n,  // active low
  input  keyer_time_pkg::key_timing_t timing,
  input  keyer_time_pkg::phase_t      tone_step,
  output logic                        tx_en,          // ptt
  output logic                        key_on,         // carrier key
  output logic                        sidetone,
  output logic                        tick_1ms
);

  import keyer_ctrl_pkg::*;

  logic [1:0]   paddle_n;   // by paddle_idx_e
  logic [1:0]   pressed;
  paddle_ctrl_t ctrl [2];

  assign paddle_n[DOT]  = paddle_dot_n;
  assign paddle_n[DASH] = paddle_dash_n;

  // ----------------------------------------------------------------------
  // 1 ms time base
  // ----------------------------------------------------------------------
  ms_tick_gen tick_i (
    .clk      (clk),
    .rstb     (rstb),
    .tick_1ms (tick_1ms)
  );

  // one debouncer per paddle
  for (genvar i = int'(DOT); i <= int'(DASH); i++) begin : debounce_g
    paddle_debounce debounce_i (
      .clk      (clk),
      .rstb     (rstb),
      .tick     (tick_1ms),
      .paddle_n (paddle_n[i]),
      .ctrl     (ctrl[i]),
      .pressed  (pressed[i])
    );
  end

  // ----------------------------------------------------------------------
  // sequencer and sidetone
  // ----------------------------------------------------------------------
  iambic_sequencer seq_i (
    .clk       (clk),
    .rstb      (rstb),
    .tick      (tick_1ms),
    .timing    (timing),
    .dot_on    (pressed[DOT]),
    .dash_on   (pressed[DASH]),
    .dot_ctrl  (ctrl[DOT]),
    .dash_ctrl (ctrl[DASH]),
    .tx_en     (tx_en),
    .key_on    (key_on)
  );

  sidetone_gen tone_i (
    .clk       (clk),
    .rstb      (rstb),
    .key_on    (key_on),
    .tone_step (tone_step),
    .sidetone  (sidetone)
  );

endmodule

`default_nettype wire

/* rtl/iambic_sequencer.sv */
// ----------------------------------------------------------------------
// iambic keyer sequencer
// turns debounced paddles into timed dots and dashes, drives tx_en with
// relay lead and break-in hang, and steers the paddle debouncers
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "keyer_cfg.svh"

module iambic_sequencer (
  input  logic                         clk,
  input  logic                         rstb,
  input  logic                         tick,
  input  keyer_time_pkg::key_timing_t  timing,
  input  logic                         dot_on,     // debounced dot paddle
  input  logic                         dash_on,    // debounced dash paddle
  output keyer_ctrl_pkg::paddle_ctrl_t dot_ctrl,
  output keyer_ctrl_pkg::paddle_ctrl_t dash_ctrl,
  output logic                         tx_en,
  output logic                         key_on
);

  import keyer_time_pkg::*;
  import keyer_ctrl_pkg::*;

  keyer_state_e state;
  ms_t          delay;      // ticks left in state, minus one
  ms_t          dash_ms;    // 3 dots plus weight
  ms_t          win_ms;     // capture window, quarter dot plus adjust
  logic         expired;
  logic         early;      // more than the window left in state

  assign dash_ms = ms_t'(3 * timing.dot_ms + timing.dash_adj_ms);
  assign win_ms  = (timing.dot_ms >> 2) + ms_t'(`KEYER_ADJ_MS);
  assign expired = (delay == '0);
  assign early   = (delay >= win_ms);

  // ----------------------------------------------------------------------
  // state machine, a state loaded with D lasts D+1 ticks
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      state <= RX;
      delay <= '0;
    end else if (tick) begin
      case (state)
        RX: begin
          if (dot_on) begin            // dot wins a tie
            state <= DOT_PRE;
            delay <= timing.relay_ms;
          end else if (dash_on) begin
            state <= DASH_PRE;
            delay <= timing.relay_ms;
          end
        end

        DOT_PRE: begin
          if (expired) begin
            state <= DOT_ON;
            delay <= timing.dot_ms;
          end else begin
            delay <= delay - 1'b1;
          end
        end

        DASH_PRE: begin
          if (expired) begin
            state <= DASH_ON;
            delay <= dash_ms;
          end else begin
            delay <= delay - 1'b1;
          end
        end

        DOT_ON, DASH_ON: begin
          if (expired) begin
            // element space is one dot either way
            state <= (state == DOT_ON) ? DOT_OFF : DASH_OFF;
            delay <= timing.dot_ms;
          end else begin
            delay <= delay - 1'b1;
          end
        end

        DOT_OFF: begin
          if (!expired) begin
            delay <= delay - 1'b1;
          end else if (dash_on) begin  // squeeze alternates
            state <= DASH_ON;
            delay <= dash_ms;
          end else if (dot_on) begin
            state <= DOT_ON;
            delay <= timing.dot_ms;
          end else begin
            state <= TR_DLY;
            delay <= timing.breakin_ms;
          end
        end

        DASH_OFF: begin
          if (!expired) begin
            delay <= delay - 1'b1;
          end else if (dot_on) begin   // squeeze alternates
            state <= DOT_ON;
            delay <= timing.dot_ms;
          end else if (dash_on) begin
            state <= DASH_ON;
            delay <= dash_ms;
          end else begin
            state <= TR_DLY;
            delay <= timing.breakin_ms;
          end
        end

        TR_DLY: begin
          // tx still on, so no relay lead when keying resumes
          if (expired) begin
            state <= RX;
          end else if (dot_on) begin
            state <= DOT_ON;
            delay <= timing.dot_ms;
          end else if (dash_on) begin
            state <= DASH_ON;
            delay <= dash_ms;
          end else begin
            delay <= delay - 1'b1;
          end
        end

        default: begin
          state <= RX;
          delay <= '0;
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // keying outputs, one tick behind the state
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      tx_en  <= 1'b0;
      key_on <= 1'b0;
    end else if (tick) begin
      tx_en  <= (state != RX);
      key_on <= (state == DOT_ON) || (state == DASH_ON);
    end
  end

  // ----------------------------------------------------------------------
  // debouncer steering
  // ----------------------------------------------------------------------
  // own element wipes its paddle, the opposite one is wiped early in the
  // element and captured near its end; own space freezes early on
  assign dot_ctrl.clear  = (state == DOT_ON) || ((state == DASH_ON) && early);
  assign dot_ctrl.hold   = (state == DOT_OFF) && early;
  assign dash_ctrl.clear = (state == DASH_ON) || ((state == DOT_ON) && early);
  assign dash_ctrl.hold  = (state == DASH_OFF) && early;

endmodule

`default_nettype wire

/* rtl/keyer_ctrl_pkg.sv */
// ----------------------------------------------------------------------
// keyer control types
// sequencer states and paddle debouncer control
// ----------------------------------------------------------------------
`default_nettype none

package keyer_ctrl_pkg;

  // iambic sequencer states
  typedef enum logic [2:0] {
    RX       = 3'd0,  // idle, tx off
    DOT_PRE  = 3'd1,  // relay lead before a dot
    DOT_ON   = 3'd2,
    DOT_OFF  = 3'd3,  // space after dot
    DASH_PRE = 3'd4,  // relay lead before a dash
    DASH_ON  = 3'd5,
    DASH_OFF = 3'd6,  // space after dash
    TR_DLY   = 3'd7   // break-in hang
  } keyer_state_e;

  // per paddle count control from the sequencer
  typedef struct packed {
    logic clear;  // zero the count
    logic hold;   // freeze the count
  } paddle_ctrl_t;

  // paddle index, also the debouncer loop index
  typedef enum int {
    DOT  = 0,
    DASH = 1
  } paddle_idx_e;

endpackage

`default_nettype wire

/* rtl/keyer_time_pkg.sv */
// ----------------------------------------------------------------------
// keyer timing types
// millisecond durations, sidetone phase and the host timing settings
// ----------------------------------------------------------------------
`default_nettype none

`include "keyer_cfg.svh"

package keyer_time_pkg;

  // duration in 1 ms ticks
  typedef logic [9:0] ms_t;

  // sidetone phase or per-clk phase step
  typedef logic [`KEYER_PHASE_W-1:0] phase_t;

  // host supplied keying times, quasi-static
  // only changed while tx_en is low
  typedef struct packed {
    ms_t dot_ms;       // dot width
    ms_t dash_adj_ms;  // dash weight on top of 3 dots
    ms_t breakin_ms;   // tx hang after last element
    ms_t relay_ms;     // tx_en lead over first key_on
  } key_timing_t;

endpackage

`default_nettype wire

/* rtl/ms_tick_gen.sv */
// ----------------------------------------------------------------------
// 1 ms time base
// divides clk down to a single cycle strobe every KEYER_CLK_PER_MS
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "keyer_cfg.svh"

module ms_tick_gen (
  input  logic clk,
  input  logic rstb,
  output logic tick_1ms
);

  localparam int CNT_W = $clog2(`KEYER_CLK_PER_MS);

  logic [CNT_W-1:0] div_cnt;   // cycles since last strobe
  logic             wrap;

  assign wrap = (div_cnt == CNT_W'(`KEYER_CLK_PER_MS - 1));

  // ----------------------------------------------------------------------
  // divider
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      div_cnt <= '0;
    end else if (wrap) begin
      div_cnt <= '0;             // restart period
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // registered strobe, first one KEYER_CLK_PER_MS cycles out of reset
  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      tick_1ms <= 1'b0;
    end else begin
      tick_1ms <= wrap;
    end
  end

endmodule

`default_nettype wire

/* rtl/paddle_debounce.sv */
// ----------------------------------------------------------------------
// paddle contact debouncer
// counts closed ticks, pressed once KEYER_REJECT_MS consecutive closures
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "keyer_cfg.svh"

module paddle_debounce (
  input  logic                         clk,
  input  logic                         rstb,
  input  logic                         tick,
  input  logic                         paddle_n,  // contact, active low
  input  keyer_ctrl_pkg::paddle_ctrl_t ctrl,
  output logic                         pressed
);

  localparam logic [3:0] REJECT = 4'(`KEYER_REJECT_MS);

  logic [3:0] close_cnt;   // consecutive closed ticks
  logic       saturated;

  assign saturated = (close_cnt == REJECT);

  // ----------------------------------------------------------------------
  // chatter rejection counter
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      close_cnt <= '0;
    end else if (tick) begin
      if (ctrl.clear) begin
        close_cnt <= '0;               // sequencer wipes the capture
      end else if (!ctrl.hold && !saturated) begin
        if (!paddle_n) begin
          close_cnt <= close_cnt + 1'b1;
        end else begin
          close_cnt <= '0;             // bounce restarts the count
        end
      end
      // saturated count is the latched press, kept until cleared
    end
  end

  assign pressed = saturated;

endmodule

`default_nettype wire

/* rtl/sidetone_gen.sv */
// ----------------------------------------------------------------------
// sidetone square wave generator
// phase accumulator gated by key_on, stops only at an msb transition
// so the tone never ends mid half cycle
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sidetone_gen (
  input  logic                   clk,
  input  logic                   rstb,
  input  logic                   key_on,
  input  keyer_time_pkg::phase_t tone_step,   // phase step per clk
  output logic                   sidetone
);

  import keyer_time_pkg::*;

  phase_t acc;        // tone phase
  logic   last_msb;   // msb one cycle back
  logic   gate;       // tone running
  logic   gate_nxt;
  logic   msb;
  logic   crossing;   // msb changed on last step

  assign msb      = acc[$bits(phase_t)-1];
  assign crossing = (msb != last_msb);
  assign gate_nxt = key_on || (gate && !crossing);  // drain to next crossing

  // ----------------------------------------------------------------------
  // accumulator and gate
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      acc      <= '0;
      last_msb <= 1'b0;
      gate     <= 1'b0;
    end else begin
      if (gate_nxt) begin
        acc <= acc + tone_step;
      end
      last_msb <= msb;   // frozen acc leaves no stale crossing
      gate     <= gate_nxt;
    end
  end

  // square out, low whenever the gate is closing or closed
  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      sidetone <= 1'b0;
    end else begin
      sidetone <= gate_nxt && msb;
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile and run the cw keyer testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module cw_keyer_tb -o cw_keyer_sim
# keep running past assertion errors so the closing line is printed
./obj_dir/cw_keyer_sim +verilator+error+limit+1000 | tee sim.log
if grep -q "Some tests failed" sim.log; then
  exit 1
fi

/* tests/cw_keyer_chk.sv */
// ----------------------------------------------------------------------
// cw keyer checker
// concurrent keying and sidetone assertions, bound into the keyer top
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cw_keyer_chk (
  input logic       clk,
  input logic       rstb,
  input logic       tick_1ms,
  input logic       tx_en,
  input logic       key_on,
  input logic       sidetone,
  input logic [1:0] pressed    // debounced paddles
);

  int fail_cnt = 0;   // failed assertions, collected by the testbench

  // all outputs quiet as reset lifts
  reset_low_a: assert property (@(posedge clk) $rose(rstb) |->
    !tx_en && !key_on && !sidetone && !tick_1ms)
    else begin
      $error("outputs not low coming out of reset");
      fail_cnt++;
    end

  // carrier only under ptt
  key_in_tx_a: assert property (@(posedge clk) disable iff (!rstb) key_on |-> tx_en)
    else begin
      $error("key_on high while tx_en low");
      fail_cnt++;
    end

  // keying moves on the 1 ms grid only
  tick_aligned_a: assert property (@(posedge clk) disable iff (!rstb)
    ($changed(key_on) || $changed(tx_en)) |-> $past(tick_1ms))
    else begin
      $error("tx_en or key_on changed off the 1 ms tick");
      fail_cnt++;
    end

  // ptt needs a debounced paddle
  tx_needs_press_a: assert property (@(posedge clk) disable iff (!rstb)
    $rose(tx_en) |-> |pressed)
    else begin
      $error("tx_en rose with no debounced paddle");
      fail_cnt++;
    end

  // tone never starts once the key is up
  tone_start_a: assert property (@(posedge clk) disable iff (!rstb)
    $rose(sidetone) |-> $past(key_on))
    else begin
      $error("sidetone rose while key_on was low");
      fail_cnt++;
    end

endmodule

bind cw_keyer_top cw_keyer_chk chk_i (
  .clk      (clk),
  .rstb     (rstb),
  .tick_1ms (tick_1ms),
  .tx_en    (tx_en),
  .key_on   (key_on),
  .sidetone (sidetone),
  .pressed  (pressed)
);

`default_nettype wire

/* tests/cw_keyer_tb.sv */
// ----------------------------------------------------------------------
// cw keyer testbench
// random timing, dot, dash, squeeze, chatter and idle paddle phases
// with a tick based pulse timing monitor
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "keyer_cfg.svh"

module cw_keyer_tb;

  import keyer_time_pkg::*;

  localparam int CLK_NS    = 40;
  localparam int REJECT    = `KEYER_REJECT_MS;
  localparam int PHASES    = 5;
  localparam int PHASE_MS  = 7 + 4 * 9 + 7 + 7 + 20;   // largest random settings
  localparam int WD_CYCLES = PHASES * 2 * `KEYER_CLK_PER_MS * PHASE_MS;

  logic        clk = 1'b0;
  logic        rstb;
  logic        paddle_dot_n;
  logic        paddle_dash_n;
  key_timing_t timing;
  phase_t      tone_step;
  logic        tx_en;
  logic        key_on;
  logic        sidetone;
  logic        tick_1ms;

  logic [31:0] lcg = 32'h7a1a;
  int          errors = 0;
  int          exp_first = 0;   // 0 none, 1 dot, 2 dash
  int          pulses = 0;
  int          half_cyc = 0;    // half tone period plus register slack
  int          tick_n = 0;
  int          tick_gap = 0;    // clk cycles since last tick
  int          tx_rise_t = 0;
  int          rise_t = 0;
  int          fall_t = 0;
  int          gap = 0;
  int          last_w = 0;
  int          key_low = 0;     // clk cycles since key_on fell
  logic        first_pulse = 1'b0;
  logic        key_q = 1'b0;
  logic        tx_q = 1'b0;

  always #(CLK_NS / 2) clk = ~clk;

  cw_keyer_top dut_i (
    .clk           (clk),
    .rstb          (rstb),
    .paddle_dot_n  (paddle_dot_n),
    .paddle_dash_n (paddle_dash_n),
    .timing        (timing),
    .tone_step     (tone_step),
    .tx_en         (tx_en),
    .key_on        (key_on),
    .sidetone      (sidetone),
    .tick_1ms      (tick_1ms)
  );

  function automatic int pick(input int lo, input int hi);
    lcg = lcg * 32'd1103515245 + 32'd12345;   // lcg step
    return lo + int'((lcg >> 16) % (hi - lo + 1));
  endfunction

  task automatic value_error(input string name, input int got, input int exp);
    $display("[ERROR] %s: got %0h expected %0h", name, got, exp);
    errors++;
  endtask

  // returns on the falling edge just ahead of the n-th tick
  task automatic wait_ticks(input int n);
    repeat (n) begin
      @(negedge clk);
      while (!tick_1ms) @(negedge clk);
    end
  endtask

  // new settings, only while tx_en is low
  task automatic set_timing();
    timing.dot_ms      = ms_t'(pick(2, 9));
    timing.dash_adj_ms = ms_t'(pick(0, 7));
    timing.breakin_ms  = ms_t'(pick(0, 7));
    timing.relay_ms    = ms_t'(pick(0, 7));
    tone_step          = phase_t'(pick(2048, 8191));
    half_cyc           = (1 << (`KEYER_PHASE_W - 1)) / int'(tone_step) + 3;
  endtask

  // ----------------------------------------------------------------------
  // pulse timing monitor, in ticks, sampled on the falling edge
  // ----------------------------------------------------------------------
  always @(negedge clk) begin
    int dot_w;
    int dash_w;
    int width;
    int alt_w;
    dot_w  = int'(timing.dot_ms) + 1;
    dash_w = 3 * int'(timing.dot_ms) + int'(timing.dash_adj_ms) + 1;
    if (rstb) begin
      if (tx_en && !tx_q) begin
        tx_rise_t   = tick_n;
        first_pulse = 1'b1;
      end
      if (key_on && !key_q) begin
        pulses++;
        rise_t = tick_n;
        gap    = tick_n - fall_t;
        if (first_pulse) begin
          assert (tick_n - tx_rise_t == int'(timing.relay_ms) + 1)
            else value_error("tx_en lead", tick_n - tx_rise_t, int'(timing.relay_ms) + 1);
        end else begin
          // one space, or a space and part of the hang
          assert (gap >= dot_w && gap <= dot_w + int'(timing.breakin_ms))
            else value_error("key_on gap", gap, dot_w);
        end
      end
      if (!key_on && key_q) begin
        width = tick_n - rise_t;
        assert (width == dot_w || width == dash_w) else begin
          $display("[ERROR] key_on width: got %0h expected %0h or %0h", width, dot_w, dash_w);
          errors++;
        end
        if (first_pulse && exp_first != 0) begin
          assert (width == ((exp_first == 1) ? dot_w : dash_w))
            else value_error("first element", width, (exp_first == 1) ? dot_w : dash_w);
        end else if (!first_pulse && gap == dot_w) begin
          // back to back means the other paddle
          alt_w = (last_w == dot_w) ? dash_w : dot_w;
          assert (width == alt_w)
            else value_error("squeeze element", width, alt_w);
        end
        last_w      = width;
        fall_t      = tick_n;
        first_pulse = 1'b0;
      end
      if (!tx_en && tx_q) begin
        // element space then break-in hang
        assert (tick_n - fall_t == dot_w + int'(timing.breakin_ms) + 1)
          else value_error("tx_en hang", tick_n - fall_t, dot_w + int'(timing.breakin_ms) + 1);
      end
      key_low = key_on ? 0 : key_low + 1;
      assert (!(sidetone && key_low > half_cyc))
        else value_error("sidetone", int'(sidetone), 0);
      if (tick_1ms) begin
        if (tick_n > 0) begin   // strobe period
          assert (tick_gap == `KEYER_CLK_PER_MS)
            else value_error("tick_1ms spacing", tick_gap, `KEYER_CLK_PER_MS);
        end
        tick_gap = 0;
        tick_n++;
      end
      tick_gap++;
      key_q = key_on;
      tx_q  = tx_en;
    end
  end

  // ----------------------------------------------------------------------
  // stimulus phases
  // ----------------------------------------------------------------------
  task automatic run_phase(input int kind);
    int first;
    set_timing();
    pulses    = 0;
    exp_first = 0;
    case (kind)
      0: begin   // single dot
        exp_first    = 1;
        paddle_dot_n = 1'b0;
        wait_ticks(REJECT + 2 + pick(0, 3));
        paddle_dot_n = 1'b1;
      end
      1: begin   // single dash
        exp_first     = 2;
        paddle_dash_n = 1'b0;
        wait_ticks(REJECT + 2 + pick(0, 3));
        paddle_dash_n = 1'b1;
      end
      2: begin   // squeeze, one paddle leads by three ticks
        first     = pick(1, 2);
        exp_first = first;
        if (first == 1) paddle_dot_n = 1'b0;
        else paddle_dash_n = 1'b0;
        wait_ticks(3);
        paddle_dot_n  = 1'b0;
        paddle_dash_n = 1'b0;
        wait_ticks(REJECT + pick(8, 30));
        paddle_dot_n  = 1'b1;
        paddle_dash_n = 1'b1;
      end
      3: begin   // chatter, closed runs shorter than the reject count
        repeat (8) begin
          paddle_dot_n = 1'b0;
          wait_ticks(pick(1, REJECT - 1));
          paddle_dot_n = 1'b1;
          wait_ticks(pick(1, 3));
        end
      end
      default: wait_ticks(40);   // idle
    endcase
    wait_ticks(2);
    while (tx_en) @(negedge clk);
    wait_ticks(2);               // sidetone drains
    if (exp_first != 0) begin
      assert (pulses > 0) else begin
        $display("no key_on seen in paddle phase %0d", kind);
        errors++;
      end
    end else begin
      assert (pulses == 0) else value_error("key_on pulses", pulses, 0);
    end
  endtask

  initial begin
    rstb          = 1'b0;
    paddle_dot_n  = 1'b1;
    paddle_dash_n = 1'b1;
    timing        = '0;
    tone_step     = '0;
    repeat (3) @(negedge clk);
    rstb = 1'b1;
    @(negedge clk);
    assert (!tx_en && !key_on && !sidetone) else begin
      $display("outputs not low after reset");
      errors++;
    end
    for (int k = 0; k < PHASES; k++) run_phase(k);
    $display("closing: %0d testbench errors, %0d assertion failures",
             errors, dut_i.chk_i.fail_cnt);
    if (errors == 0 && dut_i.chk_i.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WD_CYCLES * CLK_NS);
    $display("timeout: run did not finish within %0d clock cycles", WD_CYCLES);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire
